/* include/fano_params.svh */
`ifndef FANO_PARAMS_SVH
`define FANO_PARAMS_SVH

////////////////////////////////////////////////////////////
// Convolutional code of rate 1/2
////////////////////////////////////////////////////////////
`define FANO_K 7
// Generator taps with the current input bit in the MSB
`define FANO_G0 7'o171
`define FANO_G1 7'o133

////////////////////////////////////////////////////////////
// Frame layout and hard-decision branch weights
////////////////////////////////////////////////////////////
`define FANO_INFO_BITS 48
`define FANO_TAIL_BITS (`FANO_K - 1)
`define FANO_FRAME_SYMS (`FANO_INFO_BITS + `FANO_TAIL_BITS)
`define FANO_MATCH 1
`define FANO_MISMATCH (-5)
`endif

/* logic/fano_bit_output.sv */
`default_nettype none
`timescale 1ns/100ps
`include "fano_params.svh"

module fano_bit_output (
    input  wire                        clk,
    input  wire                        nlocal_rst,
    input  wire                        i_done,
    input  wire [`FANO_INFO_BITS-1:0]  i_bits,
    input  wire                        i_erasure,
    output logic                       o_bit_vld,
    output logic                       o_bit,
    output logic                       o_frame_vld,
    output logic                       o_erasure
);
    import fano_pkg::*;

    localparam int INFO = `FANO_INFO_BITS;

    logic [INFO-1:0] shreg;
    depth_t          remain;
    logic            frame_q;
    logic            erasure_q;

    // Bits left to send and the frame strobe after the last one
    always_ff @(posedge clk) begin
        if (!nlocal_rst) begin
            remain  <= '0;
            frame_q <= 1'b0;
        end else begin
            frame_q <= (remain == 6'd1);
            if (i_done) begin
                remain <= depth_t'(INFO);
            end else if (remain != '0) begin
                remain <= remain - 6'd1;
            end
        end
    end

    // Oldest bit sits in bit 0
    always_ff @(posedge clk) begin
        if (i_done) begin
            shreg     <= i_bits;
            erasure_q <= i_erasure;
        end else if (remain != '0) begin
            shreg <= shreg >> 1;
        end
    end

    assign o_bit_vld   = (remain != '0);
    assign o_bit       = shreg[0];
    assign o_frame_vld = frame_q;
    assign o_erasure   = erasure_q;

endmodule

`default_nettype wire

/* logic/fano_branch_unit.sv */
`default_nettype none
`timescale 1ns/100ps
`include "fano_params.svh"

module fano_branch_unit (
    input  wire                   clk,
    input  wire                   nlocal_rst,
    input  wire                   i_req,
    input  wire [`FANO_K-2:0]     i_node_state,
    input  wire fano_pkg::sym_t   i_rx_sym,
    input  wire                   i_want_worst,
    input  wire                   i_tail,
    output logic                  o_rsp_vld,
    output logic                  o_branch_bit,
    output fano_pkg::metric_t     o_branch_metric
);
    import fano_pkg::*;

    localparam logic [`FANO_K-1:0] G0 = `FANO_G0;
    localparam logic [`FANO_K-1:0] G1 = `FANO_G1;

    sym_t    code0;
    sym_t    code1;
    metric_t score0;
    metric_t score1;
    logic    best_bit;
    logic    pick;

    // Encoder output for one hypothesis placed above the node state
    function automatic sym_t encode(input logic hyp, input logic [`FANO_K-2:0] node);
        logic [`FANO_K-1:0] win;
        win = {hyp, node};
        return {^(win & G0), ^(win & G1)};
    endfunction

    // Hard-decision distance of a pair against the received pair
    function automatic metric_t pair_score(input sym_t code, input sym_t rx);
        metric_t hi;
        metric_t lo;
        hi = (code[1] == rx[1]) ? metric_t'(`FANO_MATCH) : metric_t'(`FANO_MISMATCH);
        lo = (code[0] == rx[0]) ? metric_t'(`FANO_MATCH) : metric_t'(`FANO_MISMATCH);
        return hi + lo;
    endfunction

    assign code0  = encode(1'b0, i_node_state);
    assign code1  = encode(1'b1, i_node_state);
    assign score0 = pair_score(code0, i_rx_sym);
    assign score1 = pair_score(code1, i_rx_sym);

    // Ties go toward 0
    assign best_bit = (score1 > score0);
    // Tail nodes have only the zero branch
    assign pick = i_tail ? 1'b0 : (best_bit ^ i_want_worst);

    always_ff @(posedge clk) begin
        if (!nlocal_rst) begin
            o_rsp_vld <= 1'b0;
        end else begin
            o_rsp_vld <= i_req;
        end
    end

    always_ff @(posedge clk) begin
        if (i_req) begin
            o_branch_bit    <= pick;
            o_branch_metric <= pick ? score1 : score0;
        end
    end

endmodule

`default_nettype wire

/* logic/fano_decoder.sv */
`default_nettype none
`timescale 1ns/100ps
`include "fano_params.svh"

module fano_decoder (
    input  wire                 clk,
    input  wire                 nlocal_rst,
    input  wire                 i_sym_vld,
    input  wire fano_pkg::sym_t i_sym,
    input  wire [7:0]           i_delta,
    input  wire [15:0]          i_cycle_budget,
    output logic                o_bit_vld,
    output logic                o_bit,
    output logic                o_frame_vld,
    output logic                o_erasure
);
    import fano_pkg::*;

    ////////////////////////////////////////////////////////////
    // Store and search
    ////////////////////////////////////////////////////////////
    logic                       start;
    logic                       busy;
    depth_t                     rd_depth;
    sym_t                       rd_sym;
    // Branch request and response
    logic                       req;
    logic [`FANO_K-2:0]         node_state;
    sym_t                       rx_sym;
    logic                       want_worst;
    logic                       tail;
    logic                       rsp_vld;
    logic                       branch_bit;
    metric_t                    branch_metric;
    // Decided frame
    logic                       done;
    logic [`FANO_INFO_BITS-1:0] bits;
    logic                       erasure;

    fano_symbol_store store0 (
        .clk        (clk),
        .nlocal_rst (nlocal_rst),
        .i_sym_vld  (i_sym_vld),
        .i_sym      (i_sym),
        .i_busy     (busy),
        .i_rd_depth (rd_depth),
        .o_rd_sym   (rd_sym),
        .o_start    (start)
    );

    fano_search search0 (
        .clk             (clk),
        .nlocal_rst      (nlocal_rst),
        .i_start         (start),
        .i_delta         (i_delta),
        .i_cycle_budget  (i_cycle_budget),
        .o_busy          (busy),
        .o_rd_depth      (rd_depth),
        .i_rd_sym        (rd_sym),
        .o_req           (req),
        .o_node_state    (node_state),
        .o_rx_sym        (rx_sym),
        .o_want_worst    (want_worst),
        .o_tail          (tail),
        .i_rsp_vld       (rsp_vld),
        .i_branch_bit    (branch_bit),
        .i_branch_metric (branch_metric),
        .o_done          (done),
        .o_bits          (bits),
        .o_erasure       (erasure)
    );

    ////////////////////////////////////////////////////////////
    // Branch metrics and bit stream out
    ////////////////////////////////////////////////////////////
    fano_branch_unit branch0 (
        .clk             (clk),
        .nlocal_rst      (nlocal_rst),
        .i_req           (req),
        .i_node_state    (node_state),
        .i_rx_sym        (rx_sym),
        .i_want_worst    (want_worst),
        .i_tail          (tail),
        .o_rsp_vld       (rsp_vld),
        .o_branch_bit    (branch_bit),
        .o_branch_metric (branch_metric)
    );

    fano_bit_output out0 (
        .clk         (clk),
        .nlocal_rst  (nlocal_rst),
        .i_done      (done),
        .i_bits      (bits),
        .i_erasure   (erasure),
        .o_bit_vld   (o_bit_vld),
        .o_bit       (o_bit),
        .o_frame_vld (o_frame_vld),
        .o_erasure   (o_erasure)
    );

endmodule

`default_nettype wire

/* logic/fano_pkg.sv */
`default_nettype none

package fano_pkg;

    // Path metric or running threshold
    typedef logic signed [15:0] metric_t;

    // Received pair with G0 parity in the upper bit
    typedef logic [1:0] sym_t;

    // Tree depth from 0 up to the frame length
    typedef logic [5:0] depth_t;

    // Search engine states
    typedef enum logic [2:0] {
        IDLE,
        BRANCH,
        DECIDE,
        FORWARD,
        BACK,
        DONE
    } search_state_t;

endpackage

`default_nettype wire

/* logic/fano_search.sv */
`default_nettype none
`timescale 1ns/100ps
`include "fano_params.svh"

module fano_search (
    input  wire                        clk,
    input  wire                        nlocal_rst,
    input  wire                        i_start,
    input  wire [7:0]                  i_delta,
    input  wire [15:0]                 i_cycle_budget,
    output logic                       o_busy,
    output fano_pkg::depth_t           o_rd_depth,
    input  wire fano_pkg::sym_t        i_rd_sym,
    output logic                       o_req,
    output logic [`FANO_K-2:0]         o_node_state,
    output fano_pkg::sym_t             o_rx_sym,
    output logic                       o_want_worst,
    output logic                       o_tail,
    input  wire                        i_rsp_vld,
    input  wire                        i_branch_bit,
    input  wire fano_pkg::metric_t     i_branch_metric,
    output logic                       o_done,
    output logic [`FANO_INFO_BITS-1:0] o_bits,
    output logic                       o_erasure
);
    import fano_pkg::*;

    localparam int INFO = `FANO_INFO_BITS;
    localparam int SYMS = `FANO_FRAME_SYMS;
    localparam int MEM  = `FANO_K - 1;
    // Root predecessor and a floor that keeps the threshold above it
    localparam metric_t METRIC_MIN   = 16'sh8000;
    localparam metric_t METRIC_FLOOR = 16'sh8001;

    search_state_t     state;
    depth_t            depth;
    depth_t            prev_depth;
    depth_t            next_depth;
    metric_t           thr;
    logic [15:0]       cyc_cnt;
    logic              erasure;
    // Per-depth stacks
    logic [SYMS-1:0]   path_bits;
    logic [SYMS:0]     worst_flag;
    metric_t           metric_stk [0:SYMS];
    // Latched response of the branch unit
    logic              fwd_bit;
    metric_t           fwd_metric;

    metric_t           delta_m;
    metric_t           thr_up;
    metric_t           thr_dn;
    metric_t           mc;
    metric_t           mp;
    metric_t           mpp;
    metric_t           mf;
    logic [SYMS+MEM-1:0] path_ext;
    logic              prev_tried;
    logic              over_budget;
    logic              dec_lower;
    logic              back_lower;

    ////////////////////////////////////////////////////////////
    // Metrics around the current node
    ////////////////////////////////////////////////////////////
    assign prev_depth = depth - 6'd1;
    assign next_depth = depth + 6'd1;
    assign delta_m    = metric_t'({8'd0, i_delta});
    assign thr_up     = thr + delta_m;
    assign thr_dn     = (thr > METRIC_FLOOR + delta_m) ? thr - delta_m : METRIC_FLOOR;
    assign mc         = metric_stk[depth];
    assign mp         = (depth == 6'd0) ? METRIC_MIN : metric_stk[prev_depth];
    assign mpp        = (depth < 6'd2) ? METRIC_MIN : metric_stk[depth - 6'd2];
    assign mf         = mc + i_branch_metric;
    // Worse branch used up or a tail node with no alternative
    assign prev_tried = worst_flag[prev_depth] || (prev_depth >= INFO);
    assign over_budget = (cyc_cnt >= i_cycle_budget);

    // Stuck cases that lower the threshold
    assign dec_lower  = (state == DECIDE) && i_rsp_vld && (mf < thr) && (mp < thr);
    assign back_lower = (state == BACK) && prev_tried && (mpp < thr);

    ////////////////////////////////////////////////////////////
    // Threshold search FSM
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!nlocal_rst) begin
            state   <= IDLE;
            depth   <= '0;
            thr     <= '0;
            cyc_cnt <= '0;
            erasure <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (i_start) begin
                        state   <= BRANCH;
                        depth   <= '0;
                        thr     <= '0;
                        cyc_cnt <= '0;
                        erasure <= 1'b0;
                    end
                end
                DONE: begin
                    state <= IDLE;
                end
                default: begin
                    cyc_cnt <= cyc_cnt + 16'd1;
                    if (over_budget) begin
                        // Give up and send the frame as an erasure
                        state   <= DONE;
                        erasure <= 1'b1;
                    end else begin
                        case (state)
                            BRANCH: begin
                                state <= DECIDE;
                            end
                            DECIDE: begin
                                if (i_rsp_vld) begin
                                    if (mf >= thr) begin
                                        state <= FORWARD;
                                    end else if (mp >= thr) begin
                                        state <= BACK;
                                    end else begin
                                        thr   <= thr_dn;
                                        state <= BRANCH;
                                    end
                                end
                            end
                            FORWARD: begin
                                depth <= next_depth;
                                // First visit tightens the threshold
                                if (mc < thr_up && fwd_metric >= thr_up) begin
                                    thr <= thr_up;
                                end
                                state <= (next_depth == SYMS) ? DONE : BRANCH;
                            end
                            BACK: begin
                                depth <= prev_depth;
                                if (!prev_tried) begin
                                    state <= BRANCH;
                                end else if (back_lower) begin
                                    thr   <= thr_dn;
                                    state <= BRANCH;
                                end else begin
                                    // Keep retreating
                                    state <= BACK;
                                end
                            end
                            default: begin
                                state <= IDLE;
                            end
                        endcase
                    end
                end
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // Stacks of bits, flags and metrics
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (state == IDLE && i_start) begin
            worst_flag[0] <= 1'b0;
            metric_stk[0] <= '0;
        end
        if (state == DECIDE && i_rsp_vld) begin
            fwd_bit    <= i_branch_bit;
            fwd_metric <= mf;
        end
        // Lowered threshold retries the best branch
        if (dec_lower) begin
            worst_flag[depth] <= 1'b0;
        end
        if (state == FORWARD) begin
            path_bits[depth]       <= fwd_bit;
            metric_stk[next_depth] <= fwd_metric;
            worst_flag[next_depth] <= 1'b0;
        end
        if (state == BACK) begin
            if (!prev_tried) begin
                worst_flag[prev_depth] <= 1'b1;
            end else if (back_lower) begin
                worst_flag[prev_depth] <= 1'b0;
            end
        end
    end

    // Node state is the last six decided bits with the newest on top
    assign path_ext     = {path_bits, {MEM{1'b0}}};
    assign o_node_state = path_ext[depth +: MEM];

    assign o_busy       = (state != IDLE);
    assign o_rd_depth   = depth;
    assign o_req        = (state == BRANCH);
    assign o_rx_sym     = i_rd_sym;
    assign o_want_worst = worst_flag[depth];
    assign o_tail       = (depth >= INFO);
    assign o_done       = (state == DONE);
    assign o_bits       = path_bits[INFO-1:0];
    assign o_erasure    = erasure;

endmodule

`default_nettype wire

/* logic/fano_symbol_store.sv */
`default_nettype none
`timescale 1ns/100ps
`include "fano_params.svh"

module fano_symbol_store (
    input  wire              clk,
    input  wire              nlocal_rst,
    input  wire              i_sym_vld,
    input  wire fano_pkg::sym_t   i_sym,
    input  wire              i_busy,
    input  wire fano_pkg::depth_t i_rd_depth,
    output fano_pkg::sym_t   o_rd_sym,
    output logic             o_start
);
    import fano_pkg::*;

    localparam int SYMS = `FANO_FRAME_SYMS;

    sym_t   mem [0:SYMS-1];
    depth_t wr_cnt;
    logic   full;
    logic   busy_q;
    logic   accept;

    // Input is dropped while a frame waits or is in work
    assign accept = i_sym_vld && !full && !i_busy;

    always_ff @(posedge clk) begin
        if (!nlocal_rst) begin
            wr_cnt  <= '0;
            full    <= 1'b0;
            busy_q  <= 1'b0;
            o_start <= 1'b0;
        end else begin
            busy_q  <= i_busy;
            o_start <= accept && (wr_cnt == SYMS - 1);
            if (accept) begin
                // Last pair of the frame
                if (wr_cnt == SYMS - 1) begin
                    wr_cnt <= '0;
                    full   <= 1'b1;
                end else begin
                    wr_cnt <= wr_cnt + 6'd1;
                end
            end else if (busy_q && !i_busy) begin
                // Search finished so the store is free again
                full <= 1'b0;
            end
        end
    end

    // Pairs in arrival order
    always_ff @(posedge clk) begin
        if (accept) begin
            mem[wr_cnt] <= i_sym;
        end
    end

    assign o_rd_sym = (i_rd_depth < SYMS) ? mem[i_rd_depth] : '0;

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Build and run the Fano decoder testbench with Verilator
cd "$(dirname "$0")" || exit 1

OBJ=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module fano_decoder_tb -Mdir "$OBJ" -f sources.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$OBJ/Vfano_decoder_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "Test OK" "$LOG"; then
    echo "Simulation passed"
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1

/* sources.f */
+incdir+include
logic/fano_pkg.sv
logic/fano_symbol_store.sv
logic/fano_branch_unit.sv
logic/fano_search.sv
logic/fano_bit_output.sv
logic/fano_decoder.sv
verif/fano_decoder_props.sv
verif/fano_decoder_tb.sv

/* verif/fano_decoder_props.sv */
`default_nettype none
`timescale 1ns/100ps
`include "fano_params.svh"

module fano_decoder_props (
    input wire clk,
    input wire nlocal_rst,
    input wire i_bit_vld,
    input wire i_frame_vld
);

    logic [6:0] bit_cnt;

    // Bit strobes since the last frame strobe
    always_ff @(posedge clk) begin
        if (!nlocal_rst) begin
            bit_cnt <= '0;
        end else if (i_frame_vld) begin
            bit_cnt <= '0;
        end else if (i_bit_vld) begin
            bit_cnt <= bit_cnt + 7'd1;
        end
    end

    ////////////////////////////////////////////////////////////
    // Output strobes
    ////////////////////////////////////////////////////////////
    a_strobes_apart: assert property (@(posedge clk) disable iff (!nlocal_rst)
        !(i_bit_vld && i_frame_vld))
        else $error("bit strobe and frame strobe in the same cycle");

    a_quiet_after_reset: assert property (@(posedge clk)
        !nlocal_rst |=> (!i_bit_vld && !i_frame_vld))
        else $error("output strobe high in the cycle after reset");

    // Whole frame of bits before each frame strobe
    a_bits_per_frame: assert property (@(posedge clk) disable iff (!nlocal_rst)
        i_frame_vld |-> (bit_cnt == 7'(`FANO_INFO_BITS)))
        else $error("wrong number of bit strobes before the frame strobe");

endmodule

`default_nettype wire

/* verif/fano_decoder_tb.sv */
`default_nettype none
`timescale 1ns/100ps
`include "fano_params.svh"

module fano_decoder_tb;
    import fano_pkg::*;

    localparam int INFO    = `FANO_INFO_BITS;
    localparam int SYMS    = `FANO_FRAME_SYMS;
    localparam int TIMEOUT = 20000;
    // Encoder taps with the newest bit in the MSB
    localparam logic [6:0] TAP0 = `FANO_G0;
    localparam logic [6:0] TAP1 = `FANO_G1;

    logic        clk;
    logic        nlocal_rst;
    logic        i_sym_vld;
    sym_t        i_sym;
    logic [7:0]  i_delta;
    logic [15:0] i_cycle_budget;
    logic        o_bit_vld;
    logic        o_bit;
    logic        o_frame_vld;
    logic        o_erasure;

    // Sent frame and its channel symbols
    logic [INFO-1:0] info_bits;
    sym_t            chan [0:SYMS-1];
    logic            run_passed;
    logic            fail_printed;

    fano_decoder dut0 (
        .clk            (clk),
        .nlocal_rst     (nlocal_rst),
        .i_sym_vld      (i_sym_vld),
        .i_sym          (i_sym),
        .i_delta        (i_delta),
        .i_cycle_budget (i_cycle_budget),
        .o_bit_vld      (o_bit_vld),
        .o_bit          (o_bit),
        .o_frame_vld    (o_frame_vld),
        .o_erasure      (o_erasure)
    );

    bind fano_decoder fano_decoder_props props0 (
        .clk         (clk),
        .nlocal_rst  (nlocal_rst),
        .i_bit_vld   (o_bit_vld),
        .i_frame_vld (o_frame_vld)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // Failure reporting
    ////////////////////////////////////////////////////////////
    task automatic abort_run();
        fail_printed = 1'b1;
        $display("Test FAILED");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic fail_plain(input string msg);
        $display("ERROR: %s", msg);
        abort_run();
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("CHECK FAILED %s expected=%b actual=%b", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_erasure(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("CHECK FAILED %s erasure expected=%b actual=%b", name, exp, act);
            abort_run();
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Frame model with random bits, encoder and channel
    ////////////////////////////////////////////////////////////
    task automatic make_frame();
        logic [6:0] sr;
        logic       b;
        sr = '0;
        for (int i = 0; i < INFO; i++) begin
            info_bits[i] = ($urandom_range(0, 1) == 1);
        end
        // Shift register with the zero tail flushed in
        for (int i = 0; i < SYMS; i++) begin
            b = (i < INFO) ? info_bits[i] : 1'b0;
            sr = {b, sr[6:1]};
            chan[i] = {^(sr & TAP0), ^(sr & TAP1)};
        end
    endtask

    // Position counts channel bits at two per pair
    task automatic flip_channel_bit(input int pos);
        sym_t s;
        s = chan[pos / 2];
        s[pos % 2] = ~s[pos % 2];
        chan[pos / 2] = s;
    endtask

    // One pair every second cycle
    task automatic send_frame();
        for (int i = 0; i < SYMS; i++) begin
            @(negedge clk);
            i_sym_vld = 1'b1;
            i_sym     = chan[i];
            @(negedge clk);
            i_sym_vld = 1'b0;
        end
    endtask

    // Junk pairs until the decoder starts streaming
    task automatic send_junk_until_output(input string name);
        int waited;
        waited = 0;
        while (!o_bit_vld) begin
            if (waited >= TIMEOUT) begin
                fail_plain($sformatf("%s: no decoded bits while junk was driven", name));
            end
            waited++;
            i_sym_vld = ($urandom_range(0, 1) == 1);
            i_sym     = sym_t'($urandom_range(0, 3));
            @(negedge clk);
        end
        i_sym_vld = 1'b0;
    endtask

    // Outputs sampled at the falling edge
    task automatic collect_frame(input string name, input logic exp_erasure,
                                 input logic bits_known);
        int waited;
        int nbits;
        waited = 0;
        nbits  = 0;
        while (!o_frame_vld) begin
            if (o_bit_vld) begin
                if (nbits >= INFO) begin
                    fail_plain($sformatf("%s: more than %0d bit strobes", name, INFO));
                end else if (bits_known) begin
                    check_bit($sformatf("%s bit %0d", name, nbits), info_bits[nbits], o_bit);
                end
                nbits++;
            end
            if (waited >= TIMEOUT) begin
                fail_plain($sformatf("%s: timed out waiting for the frame strobe", name));
            end
            waited++;
            @(negedge clk);
        end
        if (nbits != INFO) begin
            fail_plain($sformatf("%s: got %0d bit strobes instead of %0d", name, nbits, INFO));
        end
        check_erasure(name, exp_erasure, o_erasure);
    endtask

    ////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////
    initial begin
        int p1;
        int p2;
        run_passed     = 1'b0;
        fail_printed   = 1'b0;
        void'($urandom(55));
        nlocal_rst     = 1'b0;
        i_sym_vld      = 1'b0;
        i_sym          = '0;
        i_delta        = 8'd2;
        i_cycle_budget = 16'd60000;
        repeat (2) @(posedge clk);
        @(negedge clk);
        nlocal_rst = 1'b1;

        // Clean channel
        for (int f = 0; f < 10; f++) begin
            make_frame();
            send_frame();
            collect_frame($sformatf("clean frame %0d", f), 1'b0, 1'b1);
        end
        // One flipped channel bit
        for (int f = 0; f < 10; f++) begin
            make_frame();
            flip_channel_bit($urandom_range(0, 2 * SYMS - 1));
            send_frame();
            collect_frame($sformatf("single error frame %0d", f), 1'b0, 1'b1);
        end
        // Two errors at least 20 pairs apart
        for (int f = 0; f < 10; f++) begin
            make_frame();
            p1 = $urandom_range(0, SYMS - 21);
            p2 = $urandom_range(p1 + 20, SYMS - 1);
            flip_channel_bit(2 * p1 + $urandom_range(0, 1));
            flip_channel_bit(2 * p2 + $urandom_range(0, 1));
            send_frame();
            collect_frame($sformatf("double error frame %0d", f), 1'b0, 1'b1);
        end
        // Input while busy is dropped
        make_frame();
        send_frame();
        send_junk_until_output("junk during decode");
        collect_frame("junk during decode", 1'b0, 1'b1);
        make_frame();
        send_frame();
        collect_frame("frame after junk", 1'b0, 1'b1);
        // Too small a budget for any search
        i_cycle_budget = 16'd10;
        make_frame();
        send_frame();
        collect_frame("budget exhausted", 1'b1, 1'b0);

        run_passed = 1'b1;
        $display("Test OK");
        $finish;
    end

    // Run stopped by an assertion
    final begin
        if (!run_passed && !fail_printed) begin
            $display("Test FAILED");
        end
    end

endmodule

`default_nettype wire
